/* include/mag_defines.svh */
// width and iteration macros for the vector magnitude unit
`ifndef MAG_DEFINES_SVH
`define MAG_DEFINES_SVH

// signed input component width
`define MAG_IN_W 8

`define MAG_RAD_W 16 // radicand and remainder, max 32768 fits unsigned

`define MAG_ROOT_W 8 // rounded root, max 182

`define MAG_ITER (`MAG_RAD_W / 2) // one root bit per iteration

`endif

/* hw/mag_pkg.sv */
// rounding opcode and square-root FSM state types
package mag_pkg;

    // rounding mode applied to the floor root
    typedef enum logic [1:0] {
        OP_FLOOR   = 2'd0, // keep floor root
        OP_NEAREST = 2'd1, // round to nearest
        OP_CEIL    = 2'd2  // round up on nonzero remainder
    } op_e;                // 2'd3 reserved

    // iterative root FSM
    typedef enum logic [1:0] {
        SQRT_IDLE = 2'd0,
        SQRT_CALC = 2'd1,
        SQRT_DONE = 2'd2
    } sqrt_state_e;

endpackage

/* hw/mag_stage_if.sv */
// pipeline item interface between stages, with src and dst modports
`timescale 1ns/1ps
`include "mag_defines.svh"

interface mag_stage_if;

    logic                  strobe; // one-cycle item pulse
    mag_pkg::op_e          op;     // rounding mode
    logic [`MAG_RAD_W-1:0] value;  // radicand or root
    logic [`MAG_RAD_W-1:0] rem;    // remainder, zero on sq2rt

    // data valid only while strobe is high, no ready
    modport src (
        output strobe, op, value, rem
    );

    modport dst (
        input strobe, op, value, rem
    );

endinterface

/* hw/mag_square_stage.sv */
// squaring stage: start acceptance, busy level and radicand register
`timescale 1ns/1ps
`include "mag_defines.svh"

module mag_square_stage (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  mag_pkg::op_e                i_op,
    input  logic signed [`MAG_IN_W-1:0] i_x,
    input  logic signed [`MAG_IN_W-1:0] i_y,
    input  logic                        i_done,  // final result pulse
    output logic                        o_busy,
    mag_stage_if.src                    sq
);

    logic                         accept;
    logic signed [`MAG_RAD_W-1:0] sq_x; // x*x, never negative
    logic signed [`MAG_RAD_W-1:0] sq_y;
    logic [`MAG_RAD_W-1:0]        rad_sum;

    assign accept = i_start && !o_busy; // starts while busy are dropped

    assign sq_x    = i_x * i_x;
    assign sq_y    = i_y * i_y;
    assign rad_sum = $unsigned(sq_x) + $unsigned(sq_y); // up to 32768

    assign sq.rem = '0;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sq.strobe <= 1'b0;
            o_busy    <= 1'b0;
        end else begin
            sq.strobe <= accept;
            if (accept) begin
                o_busy <= 1'b1;
            end else if (i_done) begin
                o_busy <= 1'b0; // free again after the o_valid cycle
            end
        end
    end

    // payload, only meaningful with the strobe
    always_ff @(posedge i_clk) begin
        if (accept) begin
            sq.value <= rad_sum;
            sq.op    <= i_op;
        end
    end

    // reserved opcode must not enter the pipeline
    a_op_legal: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        accept |-> (i_op inside {mag_pkg::OP_FLOOR, mag_pkg::OP_NEAREST, mag_pkg::OP_CEIL})
    );

endmodule

/* hw/mag_sqrt_stage.sv */
// iterative shift-subtract integer square root with remainder
`timescale 1ns/1ps
`include "mag_defines.svh"

module mag_sqrt_stage (
    input  logic     i_clk,
    input  logic     i_rst_n,
    mag_stage_if.dst up,
    mag_stage_if.src dn
);

    localparam int CNT_W = $clog2(`MAG_ITER);

    mag_pkg::sqrt_state_e  state;
    logic [CNT_W-1:0]      cnt;   // iteration counter
    logic [`MAG_RAD_W-1:0] x;     // radicand bits still to bring down
    logic [`MAG_RAD_W-1:0] q;     // partial root
    logic [`MAG_RAD_W+1:0] ac;    // accumulator, two bits wider
    logic [`MAG_RAD_W+1:0] trial; // ac minus {q, 01}
    mag_pkg::op_e          op_q;  // opcode carried through
    logic                  load;

    assign load  = (state == mag_pkg::SQRT_IDLE) && up.strobe;
    assign trial = ac - {q, 2'b01};

    // result only valid in DONE
    assign dn.strobe = (state == mag_pkg::SQRT_DONE);
    assign dn.value  = q;
    assign dn.rem    = ac[`MAG_RAD_W+1:2]; // drop the final two-bit shift
    assign dn.op     = op_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= mag_pkg::SQRT_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                mag_pkg::SQRT_IDLE: begin
                    if (up.strobe) begin
                        state <= mag_pkg::SQRT_CALC;
                        cnt   <= '0;
                    end
                end
                mag_pkg::SQRT_CALC: begin
                    if (cnt == CNT_W'(`MAG_ITER - 1)) begin
                        state <= mag_pkg::SQRT_DONE; // after MAG_ITER steps
                    end
                    cnt <= cnt + 1'b1;
                end
                mag_pkg::SQRT_DONE: begin
                    state <= mag_pkg::SQRT_IDLE;
                end
                default: begin
                    state <= mag_pkg::SQRT_IDLE;
                end
            endcase
        end
    end

    // datapath, loaded on each accepted item
    always_ff @(posedge i_clk) begin
        if (load) begin
            ac   <= {{`MAG_RAD_W{1'b0}}, up.value[`MAG_RAD_W-1:`MAG_RAD_W-2]};
            x    <= {up.value[`MAG_RAD_W-3:0], 2'b00};
            q    <= '0;
            op_q <= up.op;
        end else if (state == mag_pkg::SQRT_CALC) begin
            if (!trial[`MAG_RAD_W+1]) begin // trial not negative
                ac <= {trial[`MAG_RAD_W-1:0], x[`MAG_RAD_W-1:`MAG_RAD_W-2]};
                q  <= {q[`MAG_RAD_W-2:0], 1'b1};
            end else begin
                ac <= {ac[`MAG_RAD_W-1:0], x[`MAG_RAD_W-1:`MAG_RAD_W-2]};
                q  <= {q[`MAG_RAD_W-2:0], 1'b0};
            end
            x <= {x[`MAG_RAD_W-3:0], 2'b00};
        end
    end

    // squaring stage busy level must keep items out while computing
    a_strobe_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        up.strobe |-> (state == mag_pkg::SQRT_IDLE)
    );

    // floor root property: rad < (q+1)^2 means rem <= 2q
    a_rem_bound: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        dn.strobe |-> ({1'b0, dn.rem} <= {q, 1'b0})
    );

endmodule

/* hw/mag_round_stage.sv */
// opcode-driven root adjust and final result registers of the rounding stage
`timescale 1ns/1ps
`include "mag_defines.svh"

module mag_round_stage (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    mag_stage_if.dst               up,
    output logic                   o_valid,
    output logic [`MAG_ROOT_W-1:0] o_root,
    output logic [`MAG_RAD_W-1:0]  o_rem
);

    logic [`MAG_ROOT_W-1:0] floor_root;
    logic [`MAG_ROOT_W-1:0] root_adj;

    assign floor_root = up.value[`MAG_ROOT_W-1:0]; // at most 181

    always_comb begin
        root_adj = floor_root;
        case (up.op)
            mag_pkg::OP_NEAREST: begin
                // (r+1/2)^2 = r^2 + r + 1/4 so round up once rem > r
                if (up.rem > up.value) begin
                    root_adj = floor_root + 1'b1;
                end
            end
            mag_pkg::OP_CEIL: begin
                if (up.rem != '0) begin
                    root_adj = floor_root + 1'b1; // not a perfect square
                end
            end
            default: begin
                root_adj = floor_root;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_root  <= '0;
            o_rem   <= '0;
        end else begin
            o_valid <= up.strobe;
            if (up.strobe) begin
                o_root <= root_adj;
                o_rem  <= up.rem;  // floor remainder in every mode
            end
        end
    end

endmodule

/* hw/mag_top.sv */
// top level of the vector magnitude unit, three stages on plain ports
`timescale 1ns/1ps
`include "mag_defines.svh"

module mag_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_start,
    input  mag_pkg::op_e                i_op,
    input  logic signed [`MAG_IN_W-1:0] i_x,
    input  logic signed [`MAG_IN_W-1:0] i_y,
    output logic                        o_busy,
    output logic                        o_valid,
    output logic [`MAG_ROOT_W-1:0]      o_root,
    output logic [`MAG_RAD_W-1:0]       o_rem
);

    mag_stage_if sq2rt (); // radicand to root stage
    mag_stage_if rt2rd (); // floor root and remainder to rounding

    mag_square_stage u_square (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_op    (i_op),
        .i_x     (i_x),
        .i_y     (i_y),
        .i_done  (o_valid), // result out frees the pipeline
        .o_busy  (o_busy),
        .sq      (sq2rt.src)
    );

    mag_sqrt_stage u_sqrt (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .up      (sq2rt.dst),
        .dn      (rt2rd.src)
    );

    mag_round_stage u_round (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .up      (rt2rd.dst),
        .o_valid (o_valid),
        .o_root  (o_root),
        .o_rem   (o_rem)
    );

endmodule

/* test/mag_tb.sv */
// mag_top testbench with reference model, LFSR stimulus, compare tasks and watchdog
`timescale 1ns/1ps
`include "mag_defines.svh"

module mag_tb;

    localparam int NUM_TESTS   = 3 * 5 + 200 + 3; // overlap test weighs three
    localparam int WATCHDOG_NS = NUM_TESTS * 14 * 10 + 200;
    localparam int LATENCY     = 10;              // i_start edge to o_valid
    localparam int RES_W       = `MAG_ROOT_W + `MAG_RAD_W;

    logic                        i_clk;
    logic                        i_rst_n;
    logic                        i_start;
    mag_pkg::op_e                i_op;
    logic signed [`MAG_IN_W-1:0] i_x;
    logic signed [`MAG_IN_W-1:0] i_y;
    logic                        o_busy;
    logic                        o_valid;
    logic [`MAG_ROOT_W-1:0]      o_root;
    logic [`MAG_RAD_W-1:0]       o_rem;

    logic [31:0]                 lfsr;
    logic [RES_W-1:0]            exp_q[$]; // {root, rem} per accepted operand
    logic [RES_W-1:0]            exp_v;

    logic signed [`MAG_IN_W-1:0] corner_x [5] = '{0, 3, -128, 1, -128};
    logic signed [`MAG_IN_W-1:0] corner_y [5] = '{0, -4, -128, 1, 127};

    mag_top dut (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (i_start),
        .i_op    (i_op),
        .i_x     (i_x),
        .i_y     (i_y),
        .o_busy  (o_busy),
        .o_valid (o_valid),
        .o_root  (o_root),
        .o_rem   (o_rem)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_root(input logic [`MAG_ROOT_W-1:0] exp_r,
                              input logic [`MAG_ROOT_W-1:0] act_r);
        if (act_r !== exp_r) begin
            stop_with_error($sformatf("mismatch at %0t: o_root expected %0d got %0d",
                                      $time, exp_r, act_r));
        end
    endtask

    task automatic check_rem(input logic [`MAG_RAD_W-1:0] exp_r,
                             input logic [`MAG_RAD_W-1:0] act_r);
        if (act_r !== exp_r) begin
            stop_with_error($sformatf("mismatch at %0t: o_rem expected %0d got %0d",
                                      $time, exp_r, act_r));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_b, input logic act_b);
        if (act_b !== exp_b) begin
            stop_with_error($sformatf("mismatch at %0t: %s expected %0b got %0b",
                                      $time, name, exp_b, act_b));
        end
    endtask

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]}; // one step per bit
        end
    endtask

    // floor root by linear search and rounding rules per opcode
    function automatic logic [RES_W-1:0] ref_magnitude(input logic signed [`MAG_IN_W-1:0] x,
                                                       input logic signed [`MAG_IN_W-1:0] y,
                                                       input mag_pkg::op_e op);
        int rad;
        int r;
        int rem;
        int rounded;
        rad = int'(x) * int'(x) + int'(y) * int'(y);
        r   = 0;
        while ((r + 1) * (r + 1) <= rad) begin
            r++;
        end
        rem     = rad - r * r;
        rounded = r;
        if (op == mag_pkg::OP_NEAREST && rem > r) begin
            rounded = r + 1; // sqrt >= r + 1/2
        end else if (op == mag_pkg::OP_CEIL && rem != 0) begin
            rounded = r + 1;
        end
        return {rounded[`MAG_ROOT_W-1:0], rem[`MAG_RAD_W-1:0]};
    endfunction

    // one operand end to end with an optional start while busy
    task automatic run_vector(input logic signed [`MAG_IN_W-1:0] x,
                              input logic signed [`MAG_IN_W-1:0] y,
                              input mag_pkg::op_e op, input logic intrude,
                              input logic signed [`MAG_IN_W-1:0] x2,
                              input logic signed [`MAG_IN_W-1:0] y2);
        int cycles;
        @(posedge i_clk);
        #1;
        if (o_busy) begin
            stop_with_error("DUT still busy when a new operand was due");
        end
        i_start = 1'b1;
        i_x     = x;
        i_y     = y;
        i_op    = op;
        exp_q.push_back(ref_magnitude(x, y, op));
        @(posedge i_clk); // accepting edge
        #1;
        i_start = 1'b0;
        cycles  = 0;
        check_flag("o_busy", 1'b1, o_busy);
        while (!o_valid && cycles < 2 * LATENCY) begin
            @(posedge i_clk);
            #1;
            cycles++;
            check_flag("o_busy", 1'b1, o_busy);
            if (intrude && cycles == LATENCY - 1) begin
                i_start = 1'b1; // must be ignored
                i_x     = x2;
                i_y     = y2;
                i_op    = mag_pkg::OP_FLOOR;
            end else if (intrude && cycles == LATENCY) begin
                i_start = 1'b0;
            end
        end
        if (!o_valid) begin
            stop_with_error("o_valid never arrived after an accepted start");
        end
        if (cycles != LATENCY) begin
            stop_with_error($sformatf("mismatch at %0t: o_valid latency expected %0d got %0d",
                                      $time, LATENCY, cycles));
        end
        @(posedge i_clk);
        #1;
        check_flag("o_valid", 1'b0, o_valid); // single-cycle pulse
        check_flag("o_busy", 1'b0, o_busy);
        if (intrude) begin
            repeat (2 * LATENCY) begin
                @(posedge i_clk);
                #1;
                check_flag("o_valid", 1'b0, o_valid);
            end
        end
    endtask

    // compare process sampled mid-cycle
    always @(negedge i_clk) begin
        if (i_rst_n && o_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_error("o_valid pulsed with no accepted operand pending");
            end else begin
                exp_v = exp_q.pop_front();
                check_root(exp_v[RES_W-1:`MAG_RAD_W], o_root);
                check_rem(exp_v[`MAG_RAD_W-1:0], o_rem);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("timeout: the run took longer than the watchdog limit");
    end

    initial begin
        logic [31:0]                 bits;
        logic signed [`MAG_IN_W-1:0] rx;
        logic signed [`MAG_IN_W-1:0] ry;
        mag_pkg::op_e                rop;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_op    = mag_pkg::OP_FLOOR;
        i_x     = '0;
        i_y     = '0;
        lfsr    = 32'hcde7e543;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        check_flag("o_valid", 1'b0, o_valid);
        check_flag("o_busy", 1'b0, o_busy);
        check_root('0, o_root);
        check_rem('0, o_rem);
        for (int k = 0; k < 3; k++) begin
            for (int v = 0; v < 5; v++) begin
                run_vector(corner_x[v], corner_y[v], mag_pkg::op_e'(k), 1'b0, '0, '0);
            end
        end
        for (int n = 0; n < 200; n++) begin
            draw_bits(`MAG_IN_W, bits);
            rx = bits[`MAG_IN_W-1:0];
            draw_bits(`MAG_IN_W, bits);
            ry = bits[`MAG_IN_W-1:0];
            draw_bits(2, bits);
            rop = (bits[1:0] == 2'd3) ? mag_pkg::OP_FLOOR : mag_pkg::op_e'(bits[1:0]);
            run_vector(rx, ry, rop, 1'b0, '0, '0);
        end
        run_vector(8'sd100, -8'sd75, mag_pkg::OP_CEIL, 1'b1, -8'sd128, -8'sd128);
        repeat (2) @(posedge i_clk);
        if (exp_q.size() != 0) begin
            stop_with_error("some accepted operands never produced a result");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* tb.f */
+incdir+include
hw/mag_pkg.sv
hw/mag_stage_if.sv
hw/mag_square_stage.sv
hw/mag_sqrt_stage.sv
hw/mag_round_stage.sv
hw/mag_top.sv
test/mag_tb.sv
